/* source/cacheGeometryPkg.sv */
package cacheGeometryPkg;

    // A byte address. The low three bits select a byte inside the word.
    typedef logic [63:0] addrT;

    // One data word. It is also one cache line.
    typedef logic [63:0] dataT;

    // Byte enables of a store. Bit n covers bits 8n+7 down to 8n.
    typedef logic [7:0] maskT;

    // Address bits 63..5.
    typedef logic [58:0] tagT;

    // Address bits 4..3 select the set.
    typedef logic [1:0] indexT;

    typedef logic wayT;

    localparam int numSets = 4;
    localparam int numWays = 2;

endpackage

/* source/memoryTimingPkg.sv */
package memoryTimingPkg;

    // Main memory holds 256 words, addressed by byte address bits 10..3.
    localparam int memDepth = 256;

    typedef logic [7:0] memAddrT;

    typedef logic [3:0] latencyT;

    // Cycles from the start of an access until its data may be used.
    localparam latencyT readLatency = 4'd4;
    localparam latencyT writeLatency = 4'd3;

endpackage

/* source/latencyTimer.sv */
`timescale 1ns/10ps

module latencyTimer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  memoryTimingPkg::latencyT duration,
    output logic                     done
);
    import memoryTimingPkg::*;

    latencyT count;
    logic    busy;

    assign busy = (count != '0);

    // The count is loaded on start and runs down to zero. The done pulse
    // comes on the edge where it reaches zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            done <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
            done <= (count == latencyT'(1));
        end else begin
            done <= 1'b0;
            if (start) begin
                count <= duration;
            end
        end
    end

endmodule

/* source/mainMemory.sv */
`timescale 1ns/10ps

module mainMemory (
    input  logic                     clk,
    input  logic                     readEnable,
    input  logic                     writeEnable,
    input  memoryTimingPkg::memAddrT address,
    input  cacheGeometryPkg::dataT   writeData,
    input  cacheGeometryPkg::maskT   writeMask,
    output cacheGeometryPkg::dataT   readData
);
    import cacheGeometryPkg::*;
    import memoryTimingPkg::*;

    dataT storage [memDepth];

    // Only the enabled bytes of the addressed word change.
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            for (int b = 0; b < $bits(maskT); b++) begin
                if (writeMask[b]) begin
                    storage[address][8*b +: 8] <= writeData[8*b +: 8];
                end
            end
        end
    end

    // Read data is registered and holds its value until the next read.
    always_ff @(posedge clk) begin
        if (readEnable) begin
            readData <= storage[address];
        end
    end

endmodule

/* source/cacheArray.sv */
`timescale 1ns/10ps

module cacheArray (
    input  logic                   clk,
    input  logic                   rst,
    input  cacheGeometryPkg::addrT lookupAddress,
    output logic                   hit,
    output cacheGeometryPkg::dataT hitData,
    input  logic                   fillEnable,
    input  cacheGeometryPkg::dataT fillData,
    input  logic                   storeEnable,
    input  cacheGeometryPkg::dataT storeData,
    input  cacheGeometryPkg::maskT storeMask
);
    import cacheGeometryPkg::*;

    dataT lineData [numWays][numSets];
    tagT  lineTag [numWays][numSets];
    logic lineValid [numWays][numSets];
    wayT  victim [numSets];

    tagT                lookupTag;
    indexT              setIndex;
    logic [numWays-1:0] wayMatch;
    wayT                hitWay;
    wayT                fillWay;

    assign lookupTag = lookupAddress[63:5];
    assign setIndex = lookupAddress[4:3];

    always_comb begin
        for (int w = 0; w < numWays; w++) begin
            wayMatch[w] = lineValid[w][setIndex] && (lineTag[w][setIndex] == lookupTag);
        end
    end

    // A tag can live in only one way of a set, so at most one bit of wayMatch is set.
    assign hit = |wayMatch;
    assign hitWay = wayT'(wayMatch[1]);
    assign hitData = hit ? lineData[hitWay][setIndex] : '0;

    // Empty ways are used before anything is evicted.
    always_comb begin
        if (!lineValid[0][setIndex]) begin
            fillWay = 1'b0;
        end else if (!lineValid[1][setIndex]) begin
            fillWay = 1'b1;
        end else begin
            fillWay = victim[setIndex];
        end
    end

    always_ff @(posedge clk) begin
        if (fillEnable) begin
            lineData[fillWay][setIndex] <= fillData;
            lineTag[fillWay][setIndex] <= lookupTag;
        end else if (storeEnable && hit) begin
            for (int b = 0; b < $bits(maskT); b++) begin
                if (storeMask[b]) begin
                    lineData[hitWay][setIndex][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

    // After a fill the victim pointer names the other way of the set.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                for (int w = 0; w < numWays; w++) begin
                    lineValid[w][s] <= 1'b0;
                end
                victim[s] <= 1'b0;
            end
        end else if (fillEnable) begin
            lineValid[fillWay][setIndex] <= 1'b1;
            victim[setIndex] <= ~fillWay;
        end
    end

endmodule

/* source/cacheController.sv */
`timescale 1ns/10ps

module cacheController (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     reqValid,
    output logic                     reqReady,
    input  logic                     reqWrite,
    input  cacheGeometryPkg::addrT   reqAddress,
    input  cacheGeometryPkg::dataT   reqWriteData,
    input  cacheGeometryPkg::maskT   reqMask,
    output logic                     respValid,
    input  logic                     respReady,
    output cacheGeometryPkg::dataT   respData,
    input  logic                     hit,
    input  cacheGeometryPkg::dataT   hitData,
    output cacheGeometryPkg::addrT   lookupAddress,
    output logic                     fillEnable,
    output cacheGeometryPkg::dataT   fillData,
    output logic                     storeEnable,
    output cacheGeometryPkg::dataT   storeData,
    output cacheGeometryPkg::maskT   storeMask,
    output logic                     timerStart,
    output memoryTimingPkg::latencyT timerDuration,
    input  logic                     timerDone,
    output logic                     memReadEnable,
    output logic                     memWriteEnable,
    output memoryTimingPkg::memAddrT memAddress,
    output cacheGeometryPkg::dataT   memWriteData,
    output cacheGeometryPkg::maskT   memMask,
    input  cacheGeometryPkg::dataT   memReadData
);
    import cacheGeometryPkg::*;
    import memoryTimingPkg::*;

    typedef enum logic [2:0] {
        idle,
        lookup,
        memRead,
        fill,
        respond,
        memWrite
    } ctrlStateT;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      accept;
    logic      writeReg;
    addrT      addressReg;
    dataT      writeDataReg;
    maskT      maskReg;
    dataT      respDataReg;

    assign reqReady = (state == idle);
    assign accept = reqValid && reqReady;
    assign respValid = (state == respond);
    assign respData = respDataReg;

    assign lookupAddress = addressReg;
    assign storeData = writeDataReg;
    assign storeMask = maskReg;
    assign memAddress = addressReg[10:3];
    assign memWriteData = writeDataReg;
    assign memMask = maskReg;
    assign fillData = memReadData;

    // Every memory access starts in lookup. Stores also update a hitting line here.
    assign memReadEnable = (state == lookup) && !writeReg && !hit;
    assign memWriteEnable = (state == lookup) && writeReg;
    assign storeEnable = memWriteEnable;
    assign timerStart = memReadEnable || memWriteEnable;
    assign timerDuration = writeReg ? writeLatency : readLatency;
    assign fillEnable = (state == fill);

    always_comb begin
        nextState = state;
        case (state)
            idle:     if (accept) nextState = lookup;
            lookup: begin
                if (writeReg) begin
                    nextState = memWrite;
                end else if (hit) begin
                    nextState = respond;
                end else begin
                    nextState = memRead;
                end
            end
            memRead:  if (timerDone) nextState = fill;
            fill:     nextState = respond;
            respond:  if (respReady) nextState = idle;
            memWrite: if (timerDone) nextState = idle;
            default:  nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            writeReg <= reqWrite;
            addressReg <= reqAddress;
            writeDataReg <= reqWriteData;
            maskReg <= reqMask;
        end
    end

    // The response word is captured once and held through back-pressure.
    always_ff @(posedge clk) begin
        if (state == lookup && !writeReg && hit) begin
            respDataReg <= hitData;
        end else if (state == fill) begin
            respDataReg <= memReadData;
        end
    end

endmodule

/* source/cacheTop.sv */
`timescale 1ns/10ps

module cacheTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reqValid,
    output logic                   reqReady,
    input  logic                   reqWrite,
    input  cacheGeometryPkg::addrT reqAddress,
    input  cacheGeometryPkg::dataT reqWriteData,
    input  cacheGeometryPkg::maskT reqMask,
    output logic                   respValid,
    input  logic                   respReady,
    output cacheGeometryPkg::dataT respData
);
    import cacheGeometryPkg::*;
    import memoryTimingPkg::*;

    logic     hit;
    dataT     hitData;
    addrT     lookupAddress;
    logic     fillEnable;
    dataT     fillData;
    logic     storeEnable;
    dataT     storeData;
    maskT     storeMask;
    logic     timerStart;
    latencyT  timerDuration;
    logic     timerDone;
    logic     memReadEnable;
    logic     memWriteEnable;
    memAddrT  memAddress;
    dataT     memWriteData;
    maskT     memMask;
    dataT     memReadData;

    cacheController controller (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqReady(reqReady), .reqWrite(reqWrite),
        .reqAddress(reqAddress), .reqWriteData(reqWriteData), .reqMask(reqMask),
        .respValid(respValid), .respReady(respReady), .respData(respData),
        .hit(hit), .hitData(hitData), .lookupAddress(lookupAddress),
        .fillEnable(fillEnable), .fillData(fillData),
        .storeEnable(storeEnable), .storeData(storeData), .storeMask(storeMask),
        .timerStart(timerStart), .timerDuration(timerDuration), .timerDone(timerDone),
        .memReadEnable(memReadEnable), .memWriteEnable(memWriteEnable),
        .memAddress(memAddress), .memWriteData(memWriteData), .memMask(memMask),
        .memReadData(memReadData)
    );

    cacheArray cacheData (
        .clk(clk), .rst(rst),
        .lookupAddress(lookupAddress), .hit(hit), .hitData(hitData),
        .fillEnable(fillEnable), .fillData(fillData),
        .storeEnable(storeEnable), .storeData(storeData), .storeMask(storeMask)
    );

    latencyTimer timer (
        .clk(clk), .rst(rst),
        .start(timerStart), .duration(timerDuration), .done(timerDone)
    );

    mainMemory memory (
        .clk(clk),
        .readEnable(memReadEnable), .writeEnable(memWriteEnable),
        .address(memAddress), .writeData(memWriteData), .writeMask(memMask),
        .readData(memReadData)
    );

endmodule

/* bench/cacheController_asserts.sv */
`timescale 1ns/10ps

module cacheControllerAsserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   reqValid,
    input logic                   reqReady,
    input logic                   respValid,
    input logic                   respReady,
    input cacheGeometryPkg::dataT respData,
    input logic                   fillEnable,
    input logic                   timerDone
);

    // Once a request is taken the controller is busy and takes no second one.
    readyLowAfterAccept: assert property (@(posedge clk) disable iff (rst)
        reqValid && reqReady |=> !reqReady)
        else $error("reqReady stayed high after a request was accepted");

    // A response waiting for respReady must not move.
    responseHeld: assert property (@(posedge clk) disable iff (rst)
        respValid && !respReady |=> respValid && $stable(respData))
        else $error("response changed while respReady was low");

    fillFollowsDone: assert property (@(posedge clk) disable iff (rst)
        fillEnable |-> $past(timerDone))
        else $error("fillEnable came without timerDone in the cycle before");

endmodule

bind cacheController cacheControllerAsserts controllerChecks (
    .clk(clk),
    .rst(rst),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .respValid(respValid),
    .respReady(respReady),
    .respData(respData),
    .fillEnable(fillEnable),
    .timerDone(timerDone)
);

/* bench/cacheTopTb.sv */
`timescale 1ns/10ps

module cacheTopTb;
    import cacheGeometryPkg::*;
    import memoryTimingPkg::*;

    // Edges from the acceptance edge until respValid or reqReady comes up.
    localparam int hitEdges = 1;
    localparam int missEdges = int'(readLatency) + 3;
    localparam int writeEdges = int'(writeLatency) + 2;
    // The tests issue 27 requests. None takes more than a miss, a short stall and
    // a few handshake cycles, which keeps the whole run well under 400 cycles.
    localparam int cycleLimit = 400;

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    logic reqReady;
    logic reqWrite;
    addrT reqAddress;
    dataT reqWriteData;
    maskT reqMask;
    logic respValid;
    logic respReady;
    dataT respData;

    // Write-through keeps every cached line equal to its memory word, so the
    // shadow memory gives the data and the cache model only tracks tags.
    dataT shadowMem [memDepth];
    logic modelValid [numWays][numSets];
    tagT  modelTag [numWays][numSets];
    wayT  modelVictim [numSets];

    int errorCount = 0;
    int cycleCount = 0;
    int seed = 49;

    cacheTop i_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish.", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            errorCount++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    function automatic dataT mergeBytes(input dataT oldWord, input dataT newWord,
                                        input maskT mask);
        dataT merged;
        merged = oldWord;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) merged[8*b +: 8] = newWord[8*b +: 8];
        end
        return merged;
    endfunction

    function automatic logic modelHit(input addrT address);
        indexT setIdx;
        setIdx = address[4:3];
        for (int w = 0; w < numWays; w++) begin
            if (modelValid[w][setIdx] && modelTag[w][setIdx] == address[63:5]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // An empty way is filled first. Otherwise the victim goes, and the pointer
    // then names the other way.
    task automatic modelFill(input addrT address);
        indexT setIdx;
        wayT   way;
        setIdx = address[4:3];
        if (!modelValid[0][setIdx]) way = 1'b0;
        else if (!modelValid[1][setIdx]) way = 1'b1;
        else way = modelVictim[setIdx];
        modelValid[way][setIdx] = 1'b1;
        modelTag[way][setIdx] = address[63:5];
        modelVictim[setIdx] = ~way;
    endtask

    // Called with rst already high. It holds reset over three edges.
    task automatic applyReset();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < numSets; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelVictim[s] = 1'b0;
        end
    endtask

    // Returns on the edge that accepts the request.
    task automatic sendRequest(input logic write, input addrT address, input dataT data,
                               input maskT mask);
        @(posedge clk);
        reqValid <= 1'b1;
        reqWrite <= write;
        reqAddress <= address;
        reqWriteData <= data;
        reqMask <= mask;
        @(negedge clk);
        while (!reqReady) @(negedge clk);
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic writeWord(input addrT address, input dataT data, input maskT mask);
        int edges;
        edges = 0;
        sendRequest(1'b1, address, data, mask);
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
            edges++;
        end
        checkValue("write edges", 64'(writeEdges), 64'(edges));
        shadowMem[address[10:3]] = mergeBytes(shadowMem[address[10:3]], data, mask);
    endtask

    // The latency of the response tells a hit from a miss. A nonzero stall holds
    // respReady low for that many cycles once respValid is up.
    task automatic readWord(input addrT address, input int stall);
        int   edges;
        logic expectHit;
        dataT expected;
        edges = 0;
        expectHit = modelHit(address);
        expected = shadowMem[address[10:3]];
        sendRequest(1'b0, address, '0, '0);
        respReady <= (stall == 0);
        @(negedge clk);
        while (!respValid) begin
            @(negedge clk);
            edges++;
        end
        checkValue("read edges", 64'(expectHit ? hitEdges : missEdges), 64'(edges));
        checkValue("respData", expected, respData);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            checkValue("respValid", 64'(1), 64'(respValid));
            checkValue("respData", expected, respData);
            checkValue("reqReady", 64'(0), 64'(reqReady));
        end
        @(posedge clk);
        respReady <= 1'b1;
        if (stall > 0) @(posedge clk);
        @(negedge clk);
        checkValue("respValid", 64'(0), 64'(respValid));
        if (!expectHit) modelFill(address);
    endtask

    task automatic readMissThenHit();
        writeWord(64'h100, {$random(seed), $random(seed)}, 8'hFF);
        readWord(64'h100, 0);
        readWord(64'h100, 0);
    endtask

    // Set 1 keeps 0x208 until 0x228 and 0x248 have been filled behind it.
    task automatic storeMergeOnHit();
        writeWord(64'h208, {$random(seed), $random(seed)}, 8'hFF);
        writeWord(64'h228, {$random(seed), $random(seed)}, 8'hFF);
        writeWord(64'h248, {$random(seed), $random(seed)}, 8'hFF);
        readWord(64'h208, 0);
        writeWord(64'h208, {$random(seed), $random(seed)}, 8'($random(seed)));
        readWord(64'h208, 0);
        readWord(64'h228, 0);
        readWord(64'h248, 0);
        readWord(64'h208, 0);
    endtask

    task automatic storeMissNoAllocate();
        writeWord(64'h310, {$random(seed), $random(seed)}, 8'hFF);
        readWord(64'h310, 0);
    endtask

    // Three tags that share set 3. The second is read again before the first,
    // since refilling the first would evict the second. The third still hits at
    // the end, because a hit leaves the victim pointer where it was.
    task automatic victimReplacement();
        addrT aliases [3];
        aliases = '{64'h018, 64'h038, 64'h058};
        for (int i = 0; i < 3; i++) begin
            writeWord(aliases[i], {$random(seed), $random(seed)}, 8'hFF);
        end
        for (int i = 0; i < 3; i++) begin
            readWord(aliases[i], 0);
        end
        readWord(aliases[1], 0);
        readWord(aliases[0], 0);
        readWord(aliases[2], 0);
    endtask

    task automatic responseBackPressure();
        writeWord(64'h400, {$random(seed), $random(seed)}, 8'hFF);
        readWord(64'h400, 5);
        readWord(64'h400, 3);
    endtask

    task automatic resetClearsValid();
        @(posedge clk);
        rst <= 1'b1;
        applyReset();
        readWord(64'h100, 0);
    endtask

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddress = '0;
        reqWriteData = '0;
        reqMask = '0;
        respReady = 1'b1;
        applyReset();
        readMissThenHit();
        storeMergeOnHit();
        storeMissNoAllocate();
        victimReplacement();
        responseBackPressure();
        resetClearsValid();
        $display("Run finished with %0d failed checks.", errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/cacheGeometryPkg.sv
source/memoryTimingPkg.sv
source/latencyTimer.sv
source/mainMemory.sv
source/cacheArray.sv
source/cacheController.sv
source/cacheTop.sv
bench/cacheController_asserts.sv
bench/cacheTopTb.sv

/* Makefile */
# Verilator flow for the cache testbench.
VERILATOR  ?= verilator
TOP        ?= cacheTopTb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
FAIL_TEXT  ?= test failed
PASS_TEXT  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
